// File: all.f
cplxPkg.sv
cplxPipeCtrl.sv
cplxExecStage.sv
cplxRegWriteStage.sv
cplxRegFile.sv
cplxTop.sv
tbClock.sv
cplxTb.sv

// File: cplxExecStage.sv
/*
 * Two-stage multiply pipeline.
 * Stage one latches the operands, sign or zero extended per op.
 * Stage two latches the double-width product and picks the result half.
 * Op tags ride alongside so the write stage sees a complete op.
 */

`timescale 1ns/1ps
`default_nettype none

module cplxExecStage #(
    parameter int dataWidth   = 32,
    parameter int regNumWidth = 6,
    parameter int alPtrWidth  = 6
) (
    input  wire logic                   ctrl,
    input  wire logic                   rstN,
    input  wire logic                   stall,
    input  wire logic                   clear,
    input  wire logic                   issueValid,
    input  wire cplxPkg::mulOpT         issueOp,
    input  wire logic [dataWidth-1:0]   srcA,
    input  wire logic [dataWidth-1:0]   srcB,
    input  wire logic [regNumWidth-1:0] dstReg,
    input  wire logic                   writeReg,
    input  wire logic [alPtrWidth-1:0]  alPtr,
    input  wire logic [dataWidth-1:0]   pc,
    output logic                        exValid,
    output logic [dataWidth-1:0]        exData,
    output logic [regNumWidth-1:0]      exDst,
    output logic                        exWriteReg,
    output logic [alPtrWidth-1:0]       exAlPtr,
    output logic [dataWidth-1:0]        exPc
);

    // Stage one
    logic                     s1Valid;
    cplxPkg::mulOpT           s1Op;
    logic signed [dataWidth:0] s1A;
    logic signed [dataWidth:0] s1B;
    logic [regNumWidth-1:0]   s1Dst;
    logic                     s1WriteReg;
    logic [alPtrWidth-1:0]    s1AlPtr;
    logic [dataWidth-1:0]     s1Pc;
    logic                     signExt;

    // Stage two
    cplxPkg::mulOpT           s2Op;
    logic [2*dataWidth-1:0]   fullProd;
    logic [2*dataWidth-1:0]   s2Prod;

    // Only the unsigned high-half op zero extends
    assign signExt = (issueOp != cplxPkg::opMulhu);

    always_ff @(posedge ctrl) begin
        if (!rstN || clear) begin
            s1Valid <= 1'b0;
        end else if (!stall) begin
            s1Valid <= issueValid;
        end
    end

    always_ff @(posedge ctrl) begin
        if (!stall) begin
            s1Op       <= issueOp;
            s1A        <= {signExt & srcA[dataWidth-1], srcA};
            s1B        <= {signExt & srcB[dataWidth-1], srcB};
            s1Dst      <= dstReg;
            s1WriteReg <= writeReg;
            s1AlPtr    <= alPtr;
            s1Pc       <= pc;
        end
    end

    // Low 2*dataWidth bits of the extended product are exact for all ops
    assign fullProd = s1A * s1B;

    always_ff @(posedge ctrl) begin
        if (!rstN || clear) begin
            exValid <= 1'b0;
        end else if (!stall) begin
            exValid <= s1Valid;
        end
    end

    always_ff @(posedge ctrl) begin
        if (!stall) begin
            s2Op       <= s1Op;
            s2Prod     <= fullProd;
            exDst      <= s1Dst;
            exWriteReg <= s1WriteReg;
            exAlPtr    <= s1AlPtr;
            exPc       <= s1Pc;
        end
    end

    assign exData = (s2Op == cplxPkg::opMul) ? s2Prod[dataWidth-1:0]
                                             : s2Prod[2*dataWidth-1:dataWidth];

endmodule

`default_nettype wire

// File: cplxInput.txt
# S issueValid issueOp srcA srcB dstReg writeReg alPtr pc stallReq clearReq recoverStart recoverEnd flushHeadIn flushTailIn
# E alPtr pc dstReg writeReg value (expected completions in order), all fields hex
# Multiply edge operands, issued back to back
S 1 0 7fffffff 7fffffff 01 1 00 00001000 0 0 0 0 00 00
S 1 1 7fffffff 7fffffff 02 1 01 00001004 0 0 0 0 00 00
S 1 1 80000000 80000000 03 1 02 00001008 0 0 0 0 00 00
S 1 2 ffffffff ffffffff 04 1 03 0000100c 0 0 0 0 00 00
S 1 1 ffffffff ffffffff 05 1 04 00001010 0 0 0 0 00 00
S 1 0 ffffffff 00000002 06 1 05 00001014 0 0 0 0 00 00
S 1 1 80000000 00000001 07 1 06 00001018 0 0 0 0 00 00
S 1 2 80000000 00000002 08 1 07 0000101c 0 0 0 0 00 00
S 1 1 12345678 fffffff0 09 1 08 00001020 0 0 0 0 00 00
S 1 2 12345678 fffffff0 0a 1 09 00001024 0 0 0 0 00 00
S 1 0 00010000 00010000 0b 1 0a 00001028 0 0 0 0 00 00
S 1 0 0000ffff 0000ffff 0c 1 0b 0000102c 0 0 0 0 00 00
# No register write, reg 01 must keep its value
S 1 0 00000003 00000005 01 0 0c 00001030 0 0 0 0 00 00
# Stall with ops in flight, the issue during the stall is ignored
S 1 0 00000002 00000003 0d 1 0d 00001034 0 0 0 0 00 00
S 1 2 ffffffff 00000002 0e 1 0e 00001038 0 0 0 0 00 00
S 1 0 00000009 00000009 3f 1 3f dead0000 1 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 1 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 1 0 0 0 00 00
S 1 0 fffffffd 00000007 0f 1 0f 0000103c 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
# Recovery with flush range 10..11
S 1 0 11111111 00000010 02 1 10 00001040 0 0 1 0 10 12
S 1 1 40000000 40000000 03 1 11 00001044 0 0 0 0 00 00
S 1 0 00000100 00000100 10 1 12 00001048 0 0 0 0 00 00
S 1 1 ffffffff 7fffffff 11 1 13 0000104c 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 1 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
# Recovery with a range that wraps, 3e..01
S 1 2 00000003 80000000 12 1 3d 00001050 0 0 1 0 3e 02
S 1 0 00000007 00000007 04 1 3e 00001054 0 0 0 0 00 00
S 1 1 7fffffff 80000000 05 1 00 00001058 0 0 0 0 00 00
S 1 0 00000064 ffffff9c 13 1 02 0000105c 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 1 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
# Clear drops four ops, then one op completes normally
S 1 0 00000005 00000005 06 1 14 00001060 0 0 0 0 00 00
S 1 1 7fffffff 7fffffff 07 1 15 00001064 0 0 0 0 00 00
S 1 2 ffffffff ffffffff 08 1 16 00001068 0 0 0 0 00 00
S 1 0 00000002 00000002 09 1 17 0000106c 0 1 0 0 00 00
S 1 0 00000010 00000010 14 1 18 00001070 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
S 0 0 00000000 00000000 00 0 00 00000000 0 0 0 0 00 00
# Expected completions
E 00 00001000 01 1 00000001
E 01 00001004 02 1 3fffffff
E 02 00001008 03 1 40000000
E 03 0000100c 04 1 fffffffe
E 04 00001010 05 1 00000000
E 05 00001014 06 1 fffffffe
E 06 00001018 07 1 ffffffff
E 07 0000101c 08 1 00000001
E 08 00001020 09 1 fffffffe
E 09 00001024 0a 1 12345676
E 0a 00001028 0b 1 00000000
E 0b 0000102c 0c 1 fffe0001
E 0c 00001030 01 0 0000000f
E 0d 00001034 0d 1 00000006
E 0e 00001038 0e 1 00000001
E 0f 0000103c 0f 1 ffffffeb
E 12 00001048 10 1 00010000
E 13 0000104c 11 1 ffffffff
E 3d 00001050 12 1 00000001
E 02 0000105c 13 1 ffffd8f0
E 18 00001070 14 1 00000100

// File: cplxPipeCtrl.sv
/*
 * Back-end pipeline controller for the multiply path.
 * Passes stall and clear to the stages and tracks the recovery phase
 * together with the active-list range that is being flushed.
 */

`timescale 1ns/1ps
`default_nettype none

module cplxPipeCtrl #(
    parameter int alPtrWidth = 6
) (
    input  wire logic                  ctrl,
    input  wire logic                  rstN,
    input  wire logic                  stallReq,
    input  wire logic                  clearReq,
    input  wire logic                  recoverStart,
    input  wire logic                  recoverEnd,
    input  wire logic [alPtrWidth-1:0] flushHeadIn,
    input  wire logic [alPtrWidth-1:0] flushTailIn,
    output logic                       stall,
    output logic                       clear,
    output logic                       toRecovery,
    output logic [alPtrWidth-1:0]      flushHead,
    output logic [alPtrWidth-1:0]      flushTail
);

    // Stall and clear act in the cycle they are requested
    assign stall = stallReq;
    assign clear = clearReq;

    // Recovery phase starts the cycle after recoverStart
    always_ff @(posedge ctrl) begin
        if (!rstN) begin
            toRecovery <= 1'b0;
        end else if (recoverStart) begin
            toRecovery <= 1'b1;
        end else if (recoverEnd) begin
            toRecovery <= 1'b0;
        end
    end

    // Flush range is only looked at while toRecovery is high
    always_ff @(posedge ctrl) begin
        if (recoverStart) begin
            flushHead <= flushHeadIn;
            flushTail <= flushTailIn;
        end
    end

    // A recovery cannot open and close in the same cycle
    recoverPulsesExclusive: assert property (
        @(posedge ctrl) disable iff (!rstN)
        !(recoverStart && recoverEnd)
    ) else $error("recoverStart and recoverEnd high together");

endmodule

`default_nettype wire

// File: cplxPkg.sv
/*
 * Shared definitions for the complex-integer back end.
 * Holds the multiply op codes, the active-list execution states and
 * the circular flush-range check. Modules refer to these by scoped names.
 */

`default_nettype none

package cplxPkg;

    // Widest active-list pointer the flush check accepts
    localparam int maxPtrWidth = 16;

    typedef logic [maxPtrWidth-1:0] ptrArgT;

    // Result half and operand signedness of a multiply
    typedef enum logic [1:0] {
        opMul   = 2'd0,
        opMulh  = 2'd1,
        opMulhu = 2'd2
    } mulOpT;

    typedef enum logic {
        execNotFinished = 1'b0,
        execSuccess     = 1'b1
    } execStateT;

    // True when ptr lies in [head, tail) on the circular active list.
    // An empty range is head == tail
    function automatic logic inFlushRange(
        input ptrArgT ptr,
        input ptrArgT head,
        input ptrArgT tail
    );
        logic inRange;
        if (head == tail) begin
            inRange = 1'b0;
        end else if (head < tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end else begin
            // Range wraps past the end of the pointer space
            inRange = (ptr >= head) || (ptr < tail);
        end
        return inRange;
    endfunction

endpackage

`default_nettype wire

// File: cplxRegFile.sv
/*
 * Physical register file for the multiply path.
 * One synchronous write port from the write stage and one
 * combinational read port, used for debug read-back.
 */

`timescale 1ns/1ps
`default_nettype none

module cplxRegFile #(
    parameter int dataWidth   = 32,
    parameter int regNumWidth = 6
) (
    input  wire logic                   ctrl,
    input  wire logic                   rfWe,
    input  wire logic [regNumWidth-1:0] rfNum,
    input  wire logic [dataWidth-1:0]   rfData,
    input  wire logic [regNumWidth-1:0] rdNum,
    output logic [dataWidth-1:0]        rdData
);

    localparam int numRegs = 1 << regNumWidth;

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge ctrl) begin
        if (rfWe) begin
            regs[rfNum] <= rfData;
        end
    end

    // Read sees the old value during a write to the same register
    assign rdData = regs[rdNum];

endmodule

`default_nettype wire

// File: cplxRegWriteStage.sv
/*
 * Register-write stage of the multiply path.
 * Decides whether the op in its pipeline register commits, then drives
 * the register-file write port and the active-list write port.
 * Ops inside the flush range are dropped while recovering.
 */

`timescale 1ns/1ps
`default_nettype none

module cplxRegWriteStage #(
    parameter int dataWidth   = 32,
    parameter int regNumWidth = 6,
    parameter int alPtrWidth  = 6
) (
    input  wire logic                   ctrl,
    input  wire logic                   rstN,
    input  wire logic                   stall,
    input  wire logic                   clear,
    input  wire logic                   toRecovery,
    input  wire logic [alPtrWidth-1:0]  flushHead,
    input  wire logic [alPtrWidth-1:0]  flushTail,
    input  wire logic                   exValid,
    input  wire logic [dataWidth-1:0]   exData,
    input  wire logic [regNumWidth-1:0] exDst,
    input  wire logic                   exWriteReg,
    input  wire logic [alPtrWidth-1:0]  exAlPtr,
    input  wire logic [dataWidth-1:0]   exPc,
    output logic                        rfWe,
    output logic [regNumWidth-1:0]      rfNum,
    output logic [dataWidth-1:0]        rfData,
    output logic                        alWrite,
    output logic [alPtrWidth-1:0]       alPtrOut,
    output logic [dataWidth-1:0]        alPcOut,
    output cplxPkg::execStateT          alState
);

    logic                   rwValid;
    logic [dataWidth-1:0]   rwData;
    logic [regNumWidth-1:0] rwDst;
    logic                   rwWriteReg;
    logic [alPtrWidth-1:0]  rwAlPtr;
    logic [dataWidth-1:0]   rwPc;
    logic                   flush;
    logic                   update;

    always_ff @(posedge ctrl) begin
        if (!rstN || clear) begin
            rwValid <= 1'b0;
        end else if (!stall) begin
            rwValid <= exValid;
        end
    end

    always_ff @(posedge ctrl) begin
        if (!stall) begin
            rwData     <= exData;
            rwDst      <= exDst;
            rwWriteReg <= exWriteReg;
            rwAlPtr    <= exAlPtr;
            rwPc       <= exPc;
        end
    end

    // Selective flush, only while the recovery phase is open
    assign flush = toRecovery && cplxPkg::inFlushRange(cplxPkg::ptrArgT'(rwAlPtr),
                                                       cplxPkg::ptrArgT'(flushHead),
                                                       cplxPkg::ptrArgT'(flushTail));
    assign update = rwValid && !stall && !clear && !flush;

    // Register file port
    assign rfWe   = update && rwWriteReg;
    assign rfNum  = rwDst;
    assign rfData = rwData;

    // Active list port
    assign alWrite  = update;
    assign alPtrOut = rwAlPtr;
    assign alPcOut  = rwPc;
    assign alState  = update ? cplxPkg::execSuccess : cplxPkg::execNotFinished;

    // Every register write is also reported to the active list
    rfWriteReported: assert property (
        @(posedge ctrl) disable iff (!rstN)
        rfWe |-> alWrite
    ) else $error("register write without active-list write");

endmodule

`default_nettype wire

// File: cplxTb.sv
/*
 * Testbench for the multiply back end.
 * Reads per-cycle stimulus and the ordered expected completions from
 * cplxInput.txt, checks every active-list write against that list and
 * reads back the register file once all ops have completed.
 */

`timescale 1ns/1ps
`default_nettype none

module cplxTb;

    localparam int dataWidth   = 32;
    localparam int regNumWidth = 6;
    localparam int alPtrWidth  = 6;
    localparam int numRegs     = 1 << regNumWidth;
    localparam int drainCycles = 6;

    logic                   ctrl;
    logic                   rstN;
    logic                   issueValid;
    cplxPkg::mulOpT         issueOp;
    logic [dataWidth-1:0]   srcA;
    logic [dataWidth-1:0]   srcB;
    logic [regNumWidth-1:0] dstReg;
    logic                   writeReg;
    logic [alPtrWidth-1:0]  alPtr;
    logic [dataWidth-1:0]   pc;
    logic                   stallReq;
    logic                   clearReq;
    logic                   recoverStart;
    logic                   recoverEnd;
    logic [alPtrWidth-1:0]  flushHeadIn;
    logic [alPtrWidth-1:0]  flushTailIn;
    logic                   rfWe;
    logic [regNumWidth-1:0] rfNum;
    logic [dataWidth-1:0]   rfData;
    logic                   alWrite;
    logic [alPtrWidth-1:0]  alPtrOut;
    logic [dataWidth-1:0]   alPcOut;
    cplxPkg::execStateT     alState;
    logic [regNumWidth-1:0] rdNum;
    logic [dataWidth-1:0]   rdData;

    // Stimulus lines kept as text, parsed when driven
    string                  stimLines[$];
    logic [alPtrWidth-1:0]  expPtr[$];
    logic [dataWidth-1:0]   expPc[$];
    logic [regNumWidth-1:0] expDst[$];
    logic                   expWr[$];
    logic [dataWidth-1:0]   expVal[$];
    logic [dataWidth-1:0]   regExp[numRegs];
    bit                     regKnown[numRegs];

    int expIdx        = 0;
    int checkCount    = 0;
    int mismatchCount = 0;
    int otherErrors   = 0;
    int cycleCount    = 0;
    int cycleLimit    = 0;

    tbClock #(
        .halfPeriod(2), .resetCycles(8)
    ) tbClock_i (
        .ctrl(ctrl), .rstN(rstN)
    );

    cplxTop #(
        .dataWidth(dataWidth), .regNumWidth(regNumWidth), .alPtrWidth(alPtrWidth)
    ) cplxTop_i (
        .ctrl(ctrl), .rstN(rstN),
        .issueValid(issueValid), .issueOp(issueOp), .srcA(srcA), .srcB(srcB),
        .dstReg(dstReg), .writeReg(writeReg), .alPtr(alPtr), .pc(pc),
        .stallReq(stallReq), .clearReq(clearReq),
        .recoverStart(recoverStart), .recoverEnd(recoverEnd),
        .flushHeadIn(flushHeadIn), .flushTailIn(flushTailIn),
        .rfWe(rfWe), .rfNum(rfNum), .rfData(rfData),
        .alWrite(alWrite), .alPtrOut(alPtrOut), .alPcOut(alPcOut), .alState(alState),
        .rdNum(rdNum), .rdData(rdData)
    );

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic loadInput();
        int          fd;
        int          n;
        string       line;
        logic [31:0] fPtr;
        logic [31:0] fPc;
        logic [31:0] fDst;
        logic [31:0] fWr;
        logic [31:0] fVal;
        fd = $fopen("cplxInput.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file cplxInput.txt");
            otherErrors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            if (line[0] == "S") begin
                stimLines.push_back(line);
            end else if (line[0] == "E") begin
                n = $sscanf(line, "E %h %h %h %h %h", fPtr, fPc, fDst, fWr, fVal);
                if (n != 5) begin
                    $display("malformed completion line: %s", line);
                    otherErrors++;
                end else begin
                    expPtr.push_back(fPtr[alPtrWidth-1:0]);
                    expPc.push_back(fPc);
                    expDst.push_back(fDst[regNumWidth-1:0]);
                    expWr.push_back(fWr[0]);
                    expVal.push_back(fVal);
                    // Last committed write to a register is what read-back sees
                    if (fWr[0]) begin
                        regExp[fDst[regNumWidth-1:0]]   = fVal;
                        regKnown[fDst[regNumWidth-1:0]] = 1'b1;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic applyIdle();
        issueValid   <= 1'b0;
        issueOp      <= cplxPkg::opMul;
        srcA         <= '0;
        srcB         <= '0;
        dstReg       <= '0;
        writeReg     <= 1'b0;
        alPtr        <= '0;
        pc           <= '0;
        stallReq     <= 1'b0;
        clearReq     <= 1'b0;
        recoverStart <= 1'b0;
        recoverEnd   <= 1'b0;
        flushHeadIn  <= '0;
        flushTailIn  <= '0;
    endtask

    task automatic applyLine(input string line);
        int          n;
        logic [31:0] f[14];
        n = $sscanf(line, "S %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                    f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
        if (n != 14) begin
            $display("malformed stimulus line: %s", line);
            otherErrors++;
        end
        issueValid   <= f[0][0];
        issueOp      <= cplxPkg::mulOpT'(f[1][1:0]);
        srcA         <= f[2];
        srcB         <= f[3];
        dstReg       <= f[4][regNumWidth-1:0];
        writeReg     <= f[5][0];
        alPtr        <= f[6][alPtrWidth-1:0];
        pc           <= f[7];
        stallReq     <= f[8][0];
        clearReq     <= f[9][0];
        recoverStart <= f[10][0];
        recoverEnd   <= f[11][0];
        flushHeadIn  <= f[12][alPtrWidth-1:0];
        flushTailIn  <= f[13][alPtrWidth-1:0];
    endtask

    // Outputs are settled half a cycle after the driving edge
    always @(negedge ctrl) begin
        if (rstN === 1'b1) begin
            if (stallReq) begin
                assert (alWrite === 1'b0 && rfWe === 1'b0) else begin
                    $display("write port active at %0t ns while stallReq is high", $time);
                    otherErrors++;
                end
            end
            if (alWrite === 1'b1) begin
                if (expIdx >= expPtr.size()) begin
                    $display("unexpected active-list write at %0t ns for pointer %h",
                             $time, alPtrOut);
                    otherErrors++;
                end else begin
                    compareValue("alPtrOut", alPtrOut, expPtr[expIdx]);
                    compareValue("alPcOut", alPcOut, expPc[expIdx]);
                    compareValue("alState", alState, cplxPkg::execSuccess);
                    compareValue("rfWe", rfWe, expWr[expIdx]);
                    compareValue("rfNum", rfNum, expDst[expIdx]);
                    compareValue("rfData", rfData, expVal[expIdx]);
                    expIdx++;
                end
            end else begin
                assert (alWrite === 1'b0 && rfWe === 1'b0) else begin
                    $display("register write without a valid active-list write at %0t ns",
                             $time);
                    otherErrors++;
                end
            end
        end
    end

    task automatic readBack();
        for (int r = 0; r < numRegs; r++) begin
            if (regKnown[r]) begin
                @(posedge ctrl);
                rdNum <= regNumWidth'(r);
                @(negedge ctrl);
                compareValue($sformatf("rdData[%0d]", r), rdData, regExp[r]);
            end
        end
    endtask

    initial begin
        issueValid   = 1'b0;
        issueOp      = cplxPkg::opMul;
        srcA         = '0;
        srcB         = '0;
        dstReg       = '0;
        writeReg     = 1'b0;
        alPtr        = '0;
        pc           = '0;
        stallReq     = 1'b0;
        clearReq     = 1'b0;
        recoverStart = 1'b0;
        recoverEnd   = 1'b0;
        flushHeadIn  = '0;
        flushTailIn  = '0;
        rdNum        = '0;
        loadInput();
        cycleLimit = stimLines.size() + 20;
        while (rstN !== 1'b1) begin
            @(posedge ctrl);
        end
        foreach (stimLines[i]) begin
            @(posedge ctrl);
            applyLine(stimLines[i]);
            cycleCount++;
        end
        @(posedge ctrl);
        applyIdle();
        cycleCount++;
        // Remaining completions, bounded by the cycle limit
        while (expIdx < expPtr.size() && cycleCount < cycleLimit) begin
            @(posedge ctrl);
            cycleCount++;
        end
        if (expIdx < expPtr.size()) begin
            $display("timeout after %0d cycles, only %0d of %0d completions seen",
                     cycleCount, expIdx, expPtr.size());
            otherErrors++;
        end
        // Late writes from dropped ops would show up here
        repeat (drainCycles) @(posedge ctrl);
        readBack();
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 checkCount, mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cplxTop.sv
/*
 * Top level of the complex-integer back end.
 * Ties the controller, the two-stage multiplier, the write stage and
 * the physical register file together. An op issued at edge N is
 * written at edge N+3 when nothing stalls.
 */

`timescale 1ns/1ps
`default_nettype none

module cplxTop #(
    parameter int dataWidth   = 32,
    parameter int regNumWidth = 6,
    parameter int alPtrWidth  = 6
) (
    input  wire logic                   ctrl,
    input  wire logic                   rstN,
    input  wire logic                   issueValid,
    input  wire cplxPkg::mulOpT         issueOp,
    input  wire logic [dataWidth-1:0]   srcA,
    input  wire logic [dataWidth-1:0]   srcB,
    input  wire logic [regNumWidth-1:0] dstReg,
    input  wire logic                   writeReg,
    input  wire logic [alPtrWidth-1:0]  alPtr,
    input  wire logic [dataWidth-1:0]   pc,
    input  wire logic                   stallReq,
    input  wire logic                   clearReq,
    input  wire logic                   recoverStart,
    input  wire logic                   recoverEnd,
    input  wire logic [alPtrWidth-1:0]  flushHeadIn,
    input  wire logic [alPtrWidth-1:0]  flushTailIn,
    output logic                        rfWe,
    output logic [regNumWidth-1:0]      rfNum,
    output logic [dataWidth-1:0]        rfData,
    output logic                        alWrite,
    output logic [alPtrWidth-1:0]       alPtrOut,
    output logic [dataWidth-1:0]        alPcOut,
    output cplxPkg::execStateT          alState,
    input  wire logic [regNumWidth-1:0] rdNum,
    output logic [dataWidth-1:0]        rdData
);

    logic                   stall;
    logic                   clear;
    logic                   toRecovery;
    logic [alPtrWidth-1:0]  flushHead;
    logic [alPtrWidth-1:0]  flushTail;

    // Stage two to write stage
    logic                   exValid;
    logic [dataWidth-1:0]   exData;
    logic [regNumWidth-1:0] exDst;
    logic                   exWriteReg;
    logic [alPtrWidth-1:0]  exAlPtr;
    logic [dataWidth-1:0]   exPc;

    cplxPipeCtrl #(
        .alPtrWidth(alPtrWidth)
    ) cplxPipeCtrl_i (
        .ctrl(ctrl), .rstN(rstN),
        .stallReq(stallReq), .clearReq(clearReq),
        .recoverStart(recoverStart), .recoverEnd(recoverEnd),
        .flushHeadIn(flushHeadIn), .flushTailIn(flushTailIn),
        .stall(stall), .clear(clear), .toRecovery(toRecovery),
        .flushHead(flushHead), .flushTail(flushTail)
    );

    cplxExecStage #(
        .dataWidth(dataWidth), .regNumWidth(regNumWidth), .alPtrWidth(alPtrWidth)
    ) cplxExecStage_i (
        .ctrl(ctrl), .rstN(rstN), .stall(stall), .clear(clear),
        .issueValid(issueValid), .issueOp(issueOp), .srcA(srcA), .srcB(srcB),
        .dstReg(dstReg), .writeReg(writeReg), .alPtr(alPtr), .pc(pc),
        .exValid(exValid), .exData(exData), .exDst(exDst),
        .exWriteReg(exWriteReg), .exAlPtr(exAlPtr), .exPc(exPc)
    );

    cplxRegWriteStage #(
        .dataWidth(dataWidth), .regNumWidth(regNumWidth), .alPtrWidth(alPtrWidth)
    ) cplxRegWriteStage_i (
        .ctrl(ctrl), .rstN(rstN), .stall(stall), .clear(clear),
        .toRecovery(toRecovery), .flushHead(flushHead), .flushTail(flushTail),
        .exValid(exValid), .exData(exData), .exDst(exDst),
        .exWriteReg(exWriteReg), .exAlPtr(exAlPtr), .exPc(exPc),
        .rfWe(rfWe), .rfNum(rfNum), .rfData(rfData),
        .alWrite(alWrite), .alPtrOut(alPtrOut), .alPcOut(alPcOut), .alState(alState)
    );

    cplxRegFile #(
        .dataWidth(dataWidth), .regNumWidth(regNumWidth)
    ) cplxRegFile_i (
        .ctrl(ctrl), .rfWe(rfWe), .rfNum(rfNum), .rfData(rfData),
        .rdNum(rdNum), .rdData(rdData)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the multiply back-end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cplxTb -o cplxSim
./obj_dir/cplxSim > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: tbClock.sv
/*
 * Clock and reset source for the multiply back-end testbench.
 * Free-running clock with a 4 ns period and an active-low
 * synchronous reset that is held for a fixed number of cycles.
 */

`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int halfPeriod  = 2,
    parameter int resetCycles = 8
) (
    output logic ctrl,
    output logic rstN
);

    initial begin
        ctrl = 1'b0;
        forever #halfPeriod ctrl = ~ctrl;
    end

    // Release on a rising edge so the DUT sees a clean first cycle
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge ctrl);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire
